//--- filelist.f
rtl/slicePkg.sv
rtl/operandSelect.sv
rtl/multiplierStage.sv
rtl/postAdder.sv
rtl/dspSlice.sv
verification/dspSlice_properties.sv
verification/dspSlice_tb.sv

//--- Bender.yml
package:
  name: dsp_slice

sources:
  - rtl/slicePkg.sv
  - rtl/operandSelect.sv
  - rtl/multiplierStage.sv
  - rtl/postAdder.sv
  - rtl/dspSlice.sv
  - target: test
    files:
      - verification/dspSlice_properties.sv
      - verification/dspSlice_tb.sv

//--- verification/dspSlice_tb.sv
`default_nettype none

module dspSlice_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfW = slicePkg::halfWidth;
    localparam int wordW = slicePkg::wordWidth;
    localparam int accW  = slicePkg::accWidth;

    localparam int resetCycles   = 4;
    localparam int directedLimit = 64; // Directed phase needs well under this
    localparam int randomCycles  = 1500;
    localparam int timeoutCycles = resetCycles + directedLimit + randomCycles + 32;

    logic                           CLK0 = 1'b0;
    logic                           rst;
    logic                           ce0;
    logic [wordW-1:0]               mem0;
    logic [wordW-1:0]               mem1;
    logic                           aaMemSel;
    logic                           abMemSel;
    logic                           bbMemSel;
    logic                           cMemSel;
    logic                           signAA;
    logic                           signAB;
    logic                           signBA;
    logic                           signBB;
    logic                           aMuxSel;
    logic                           bMuxSel;
    logic                           subtractC;
    logic [slicePkg::cSelWidth-1:0] cMuxSel;
    logic [wordW-1:0]               result;
    logic [accW-1:0]                result54;
    logic                           eqz;

    // Pipeline model where index 1 is the oldest item still waiting for the adder
    logic [halfW-1:0]               histLow;
    logic [accW-1:0]                pendSum [2];
    logic [accW-1:0]                pendC [2];
    logic [slicePkg::cSelWidth-1:0] pendSel [2];
    logic                           pendSub [2];
    logic [accW-1:0]                expResult54;
    logic                           expEqz;

    integer seed               = 32'h7d62_e62f;
    int     cycleCount         = 0;
    int     modelMismatches    = 0;
    int     directedMismatches = 0;

    dspSlice uut (.*);

    always #50 CLK0 = ~CLK0;

    always @(posedge CLK0) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, the stimulus never finished", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [accW-1:0] widenProduct(input logic [halfW-1:0] a,
            input logic [halfW-1:0] b, input logic signA, input logic signB);
        logic [accW-1:0]  aWide;
        logic [accW-1:0]  bWide;
        logic [accW-1:0]  full;
        logic [wordW-1:0] low;
        aWide = signA ? {{(accW-halfW){a[halfW-1]}}, a} : {{(accW-halfW){1'b0}}, a};
        bWide = signB ? {{(accW-halfW){b[halfW-1]}}, b} : {{(accW-halfW){1'b0}}, b};
        full  = aWide * bWide;
        low   = full[wordW-1:0];
        // Either sign flag makes the 36-bit product signed
        return (signA || signB) ? {{(accW-wordW){low[wordW-1]}}, low} : {{(accW-wordW){1'b0}}, low};
    endfunction

    function automatic logic [accW-1:0] alignC(input logic [wordW-1:0] c);
        logic [accW-1:0] shifted;
        logic [accW-1:0] fill;
        shifted = {{(accW-wordW){c[wordW-1]}}, c} << slicePkg::resultLsb;
        fill    = c[wordW-1] ? (accW'(1) << slicePkg::resultLsb) - accW'(1) : '0;
        return shifted | fill;
    endfunction

    task automatic clearInputs();
        ce0       = 1'b1;
        mem0      = '0;
        mem1      = '0;
        aaMemSel  = 1'b0;
        abMemSel  = 1'b0;
        bbMemSel  = 1'b0;
        cMemSel   = 1'b0;
        signAA    = 1'b0;
        signAB    = 1'b0;
        signBA    = 1'b0;
        signBB    = 1'b0;
        aMuxSel   = 1'b0;
        bMuxSel   = 1'b0;
        subtractC = 1'b0;
        cMuxSel   = slicePkg::cSelZero;
    endtask

    task automatic randomizeInputs();
        logic [31:0] bits;
        bits      = $random(seed);
        ce0       = ($unsigned($random(seed)) % 5) != 0; // Stalls about one edge in five
        mem0      = wordW'({$random(seed), $random(seed)});
        mem1      = wordW'({$random(seed), $random(seed)});
        aaMemSel  = bits[0];
        abMemSel  = bits[1];
        bbMemSel  = bits[2];
        cMemSel   = bits[3];
        signAA    = bits[4];
        signAB    = bits[5];
        signBA    = bits[6];
        signBB    = bits[7];
        aMuxSel   = bits[8];
        bMuxSel   = bits[9];
        subtractC = bits[10];
        cMuxSel   = bits[12:11];
    endtask

    task automatic stepModel();
        logic [accW-1:0]  termC;
        logic [accW-1:0]  sum;
        logic [accW-1:0]  prodA;
        logic [accW-1:0]  prodB;
        logic [halfW-1:0] mulBSecond;
        int               k;
        if (rst) begin
            histLow = '0;
            for (k = 0; k < 2; k++) begin
                pendSum[k] = '0;
                pendC[k]   = '0;
                pendSel[k] = slicePkg::cSelZero;
                pendSub[k] = 1'b0;
            end
            expResult54 = '0;
            expEqz      = 1'b0;
        end else if (ce0) begin
            case (pendSel[1])
                slicePkg::cSelWord:     termC = pendC[1];
                slicePkg::cSelFeedback: termC = expResult54; // Result of the item one ahead
                default:                termC = '0;
            endcase
            sum         = pendSub[1] ? pendSum[1] - termC : pendSum[1] + termC;
            expResult54 = sum;
            expEqz      = (sum == '0);
            pendSum[1]  = pendSum[0];
            pendC[1]    = pendC[0];
            pendSel[1]  = pendSel[0];
            pendSub[1]  = pendSub[0];
            prodA = widenProduct(aaMemSel ? mem0[wordW-1:halfW] : mem0[halfW-1:0],
                abMemSel ? mem1[wordW-1:halfW] : mem1[halfW-1:0], signAA, signAB);
            mulBSecond = bbMemSel ? mem1[wordW-1:halfW] : histLow;
            prodB      = widenProduct(mem0[wordW-1:halfW], mulBSecond, signBA, signBB);
            pendSum[0] = (aMuxSel ? prodA : '0) + (bMuxSel ? prodB : '0);
            pendC[0]   = alignC(cMemSel ? mem1 : mem0);
            pendSel[0] = cMuxSel;
            pendSub[0] = subtractC;
            histLow    = mem1[halfW-1:0];
        end
    endtask

    task automatic compareValue(input string what, input logic [accW-1:0] expected,
            input logic [accW-1:0] actual, input logic directed);
        assert (actual === expected) else begin
            if (directed) begin
                directedMismatches++;
            end else begin
                modelMismatches++;
            end
            $display("mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        compareValue("result54", expResult54, result54, 1'b0);
        compareValue("result", accW'(expResult54[slicePkg::resultLsb +: wordW]),
            accW'(result), 1'b0);
        compareValue("eqz", accW'(expEqz), accW'(eqz), 1'b0);
    endtask

    // Outputs settled after the rising edge and the next inputs go in here
    task automatic advanceCycle();
        @(negedge CLK0);
        stepModel();
        checkOutputs();
    endtask

    task automatic passCWordThrough(input logic [wordW-1:0] cValue, input logic fromMem1,
            input int stallCycles);
        logic [wordW-1:0] other;
        int               k;
        other = wordW'({$random(seed), $random(seed)});
        clearInputs();
        mem0    = fromMem1 ? other : cValue;
        mem1    = fromMem1 ? cValue : other;
        cMemSel = fromMem1;
        cMuxSel = slicePkg::cSelWord;
        advanceCycle();
        clearInputs();
        ce0 = 1'b0;
        for (k = 0; k < stallCycles; k++) begin
            advanceCycle();
        end
        ce0 = 1'b1;
        advanceCycle();
        advanceCycle();
        compareValue("passed C word", accW'(cValue), accW'(result), 1'b1);
    endtask

    // Product 1 from the Mem1 history plus an all-ones C word carries out of bit 53
    task automatic wrapToZero();
        clearInputs();
        mem1 = 36'h0_0000_0001;
        advanceCycle();
        clearInputs();
        mem0    = 36'h0_0004_0000;
        mem1    = '1;
        bMuxSel = 1'b1;
        cMemSel = 1'b1;
        cMuxSel = slicePkg::cSelWord;
        advanceCycle();
        clearInputs();
        advanceCycle();
        advanceCycle();
        compareValue("wrapped result54", '0, result54, 1'b1);
        compareValue("wrapped eqz", accW'(1'b1), accW'(eqz), 1'b1);
    endtask

    task automatic cancelThroughFeedback();
        randomizeInputs();
        ce0       = 1'b1;
        bbMemSel  = 1'b1; // Keeps both items independent of the history
        aMuxSel   = 1'b1;
        bMuxSel   = 1'b1;
        subtractC = 1'b0;
        cMuxSel   = slicePkg::cSelZero;
        advanceCycle();
        subtractC = 1'b1;
        cMuxSel   = slicePkg::cSelFeedback;
        advanceCycle();
        clearInputs();
        advanceCycle();
        advanceCycle();
        compareValue("cancelled result54", '0, result54, 1'b1);
        compareValue("cancelled eqz", accW'(1'b1), accW'(eqz), 1'b1);
    endtask

    task automatic accumulateChain(input int length);
        int k;
        randomizeInputs();
        ce0     = 1'b1;
        aMuxSel = 1'b0;
        bMuxSel = 1'b0;
        cMuxSel = slicePkg::cSelWord;
        advanceCycle();
        for (k = 0; k < length; k++) begin
            randomizeInputs();
            ce0     = 1'b1;
            aMuxSel = 1'b1;
            bMuxSel = 1'b1;
            cMuxSel = slicePkg::cSelFeedback;
            advanceCycle();
        end
        clearInputs();
        advanceCycle();
        advanceCycle();
    endtask

    initial begin
        int i;
        clearInputs();
        rst = 1'b1;
        repeat (resetCycles) advanceCycle();
        rst = 1'b0;
        ce0 = 1'b0;
        advanceCycle();
        advanceCycle();
        compareValue("eqz while stalled after reset", '0, accW'(eqz), 1'b1);
        ce0 = 1'b1;
        advanceCycle(); // A zero bubble leaves the pipe here

        passCWordThrough(36'h8_1234_5678, 1'b0, 0);
        passCWordThrough(36'h3_0F0F_0F0F, 1'b1, 3);
        wrapToZero();
        repeat (4) cancelThroughFeedback();
        accumulateChain(6);

        for (i = 0; i < randomCycles; i++) begin
            randomizeInputs();
            rst = (i >= 700) && (i < 702); // One reset pulse in the middle of traffic
            advanceCycle();
        end

        $display("Errors: model %0d, directed %0d, assertions %0d",
            modelMismatches, directedMismatches, uut.props.assertFailures);
        if (modelMismatches == 0 && directedMismatches == 0 && uut.props.assertFailures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dspSlice_properties.sv
`default_nettype none

module dspSlice_properties (
    input wire logic                           CLK0,
    input wire logic                           rst,
    input wire logic                           ce0,
    input wire logic [slicePkg::wordWidth-1:0] result,
    input wire logic [slicePkg::accWidth-1:0]  result54,
    input wire logic                           eqz
);

    timeunit 1ns;
    timeprecision 1ps;

    int assertFailures = 0;

    // The flag comes out of reset inactive
    eqzLowAfterReset: assert property (@(posedge CLK0) rst |=> !eqz)
        else begin
            assertFailures++;
            $error("eqz was set in the cycle after reset");
        end

    holdOnStall: assert property (@(posedge CLK0) disable iff (rst) !ce0 |=> $stable(result54))
        else begin
            assertFailures++;
            $error("result54 changed after an edge with ce0 low");
        end

    // Result is always the window that lines up with the aligned C word
    windowMatches: assert property (@(posedge CLK0) disable iff (rst)
            result == result54[slicePkg::resultLsb +: slicePkg::wordWidth])
        else begin
            assertFailures++;
            $error("result is not the window of result54");
        end

endmodule

bind dspSlice dspSlice_properties props (
    .CLK0     (CLK0),
    .rst      (rst),
    .ce0      (ce0),
    .result   (result),
    .result54 (result54),
    .eqz      (eqz)
);

`default_nettype wire

//--- rtl/dspSlice.sv
`default_nettype none

module dspSlice (
    input  wire logic                           CLK0,
    input  wire logic                           rst,
    input  wire logic                           ce0,
    input  wire logic [slicePkg::wordWidth-1:0] mem0,
    input  wire logic [slicePkg::wordWidth-1:0] mem1,
    input  wire logic                           aaMemSel,
    input  wire logic                           abMemSel,
    input  wire logic                           bbMemSel,
    input  wire logic                           cMemSel,
    input  wire logic                           signAA,
    input  wire logic                           signAB,
    input  wire logic                           signBA,
    input  wire logic                           signBB,
    input  wire logic                           aMuxSel,
    input  wire logic                           bMuxSel,
    input  wire logic                           subtractC,
    input  wire logic [slicePkg::cSelWidth-1:0] cMuxSel,
    output logic      [slicePkg::wordWidth-1:0] result,
    output logic      [slicePkg::accWidth-1:0]  result54,
    output logic                                eqz
);

    logic [slicePkg::halfWidth-1:0] mulAOpA;
    logic [slicePkg::halfWidth-1:0] mulAOpB;
    logic [slicePkg::halfWidth-1:0] mulBOpA;
    logic [slicePkg::halfWidth-1:0] mulBOpB;
    logic [slicePkg::wordWidth-1:0] cWord;    // Already delayed to meet the products

    logic [slicePkg::accWidth-1:0]  productA;
    logic [slicePkg::accWidth-1:0]  productB;

    operandSelect operandSel (
        .CLK0     (CLK0),
        .rst      (rst),
        .ce0      (ce0),
        .mem0     (mem0),
        .mem1     (mem1),
        .aaMemSel (aaMemSel),
        .abMemSel (abMemSel),
        .bbMemSel (bbMemSel),
        .cMemSel  (cMemSel),
        .mulAOpA  (mulAOpA),
        .mulAOpB  (mulAOpB),
        .mulBOpA  (mulBOpA),
        .mulBOpB  (mulBOpB),
        .cWord    (cWord)
    );

    multiplierStage mulA (
        .CLK0    (CLK0),
        .rst     (rst),
        .ce0     (ce0),
        .opA     (mulAOpA),
        .opB     (mulAOpB),
        .signA   (signAA),
        .signB   (signAB),
        .product (productA)
    );

    multiplierStage mulB (
        .CLK0    (CLK0),
        .rst     (rst),
        .ce0     (ce0),
        .opA     (mulBOpA),
        .opB     (mulBOpB),
        .signA   (signBA),
        .signB   (signBB),
        .product (productB)
    );

    postAdder adder (
        .CLK0      (CLK0),
        .rst       (rst),
        .ce0       (ce0),
        .productA  (productA),
        .productB  (productB),
        .cWord     (cWord),
        .aMuxSel   (aMuxSel),
        .bMuxSel   (bMuxSel),
        .subtractC (subtractC),
        .cMuxSel   (cMuxSel),
        .result    (result),
        .result54  (result54),
        .eqz       (eqz)
    );

endmodule

`default_nettype wire

//--- rtl/postAdder.sv
`default_nettype none

module postAdder (
    input  wire logic                           CLK0,
    input  wire logic                           rst,
    input  wire logic                           ce0,
    input  wire logic [slicePkg::accWidth-1:0]  productA,
    input  wire logic [slicePkg::accWidth-1:0]  productB,
    input  wire logic [slicePkg::wordWidth-1:0] cWord,
    input  wire logic                           aMuxSel,
    input  wire logic                           bMuxSel,
    input  wire logic                           subtractC,
    input  wire logic [slicePkg::cSelWidth-1:0] cMuxSel,
    output logic      [slicePkg::wordWidth-1:0] result,
    output logic      [slicePkg::accWidth-1:0]  result54,
    output logic                                eqz
);

    // Controls travel with the operands through the multiplier registers
    logic                           aMuxSelStage1;
    logic                           bMuxSelStage1;
    logic                           subtractCStage1;
    logic [slicePkg::cSelWidth-1:0] cMuxSelStage1;

    logic                           aMuxSelStage2;
    logic                           bMuxSelStage2;
    logic                           subtractCStage2;
    logic [slicePkg::cSelWidth-1:0] cMuxSelStage2;

    logic [slicePkg::accWidth-1:0]  alignedC;
    logic [slicePkg::accWidth-1:0]  termA;
    logic [slicePkg::accWidth-1:0]  termB;
    logic [slicePkg::accWidth-1:0]  termC;
    logic [slicePkg::accWidth-1:0]  sum;

    always_ff @(posedge CLK0) begin
        if (rst) begin
            aMuxSelStage1   <= 1'b0;
            bMuxSelStage1   <= 1'b0;
            subtractCStage1 <= 1'b0;
            cMuxSelStage1   <= slicePkg::cSelZero;
            aMuxSelStage2   <= 1'b0;
            bMuxSelStage2   <= 1'b0;
            subtractCStage2 <= 1'b0;
            cMuxSelStage2   <= slicePkg::cSelZero;
        end else if (ce0) begin
            aMuxSelStage1   <= aMuxSel;
            bMuxSelStage1   <= bMuxSel;
            subtractCStage1 <= subtractC;
            cMuxSelStage1   <= cMuxSel;
            aMuxSelStage2   <= aMuxSelStage1;
            bMuxSelStage2   <= bMuxSelStage1;
            subtractCStage2 <= subtractCStage1;
            cMuxSelStage2   <= cMuxSelStage1;
        end
    end

    // C sits at bit resultLsb with its sign bit copied into the guard and low bits
    assign alignedC = {
        {slicePkg::qShift{cWord[slicePkg::wordWidth-1]}},
        cWord,
        {slicePkg::resultLsb{cWord[slicePkg::wordWidth-1]}}
    };

    assign termA = aMuxSelStage2 ? productA : '0;
    assign termB = bMuxSelStage2 ? productB : '0;

    always_comb begin
        case (cMuxSelStage2)
            slicePkg::cSelWord:     termC = alignedC;
            slicePkg::cSelFeedback: termC = result54; // Result of the item one ahead
            default:                termC = '0;
        endcase
    end

    // Wraps modulo 2**54
    assign sum = subtractCStage2 ? (termA + termB - termC) : (termA + termB + termC);

    always_ff @(posedge CLK0) begin
        if (rst) begin
            result54 <= '0;
            eqz      <= 1'b0;
        end else if (ce0) begin
            result54 <= sum;
            eqz      <= (sum == '0);
        end
    end

    // Same window as the aligned C word
    assign result = result54[slicePkg::resultLsb +: slicePkg::wordWidth];

endmodule

`default_nettype wire

//--- rtl/multiplierStage.sv
`default_nettype none

module multiplierStage (
    input  wire logic                          CLK0,
    input  wire logic                          rst,
    input  wire logic                          ce0,
    input  wire logic [slicePkg::halfWidth-1:0] opA,
    input  wire logic [slicePkg::halfWidth-1:0] opB,
    input  wire logic                          signA,
    input  wire logic                          signB,
    output logic      [slicePkg::accWidth-1:0]  product
);

    logic [slicePkg::halfWidth-1:0] opAReg;
    logic [slicePkg::halfWidth-1:0] opBReg;
    logic                           signAReg;
    logic                           signBReg;

    // One extra bit per operand carries either its sign or a zero
    logic signed [slicePkg::halfWidth:0]   opAExt;
    logic signed [slicePkg::halfWidth:0]   opBExt;
    logic signed [slicePkg::wordWidth-1:0] productWord;
    logic                                  productSigned;
    logic        [slicePkg::accWidth-1:0]  productWide;

    always_ff @(posedge CLK0) begin
        if (rst) begin
            opAReg   <= '0;
            opBReg   <= '0;
            signAReg <= 1'b0;
            signBReg <= 1'b0;
        end else if (ce0) begin
            opAReg   <= opA;
            opBReg   <= opB;
            signAReg <= signA;
            signBReg <= signB;
        end
    end

    assign opAExt = {signAReg & opAReg[slicePkg::halfWidth-1], opAReg};
    assign opBExt = {signBReg & opBReg[slicePkg::halfWidth-1], opBReg};

    assign productWord   = opAExt * opBExt; // The low 36 bits are exact for every mode
    assign productSigned = signAReg | signBReg;

    // An unsigned product can use bit 35 as magnitude, so it is zero-extended
    assign productWide = productSigned ?
        {{slicePkg::productExtend{productWord[slicePkg::wordWidth-1]}}, productWord} :
        {{slicePkg::productExtend{1'b0}}, productWord};

    always_ff @(posedge CLK0) begin
        if (rst) begin
            product <= '0;
        end else if (ce0) begin
            product <= productWide;
        end
    end

endmodule

`default_nettype wire

//--- rtl/operandSelect.sv
`default_nettype none

module operandSelect (
    input  wire logic                           CLK0,
    input  wire logic                           rst,
    input  wire logic                           ce0,
    input  wire logic [slicePkg::wordWidth-1:0] mem0,
    input  wire logic [slicePkg::wordWidth-1:0] mem1,
    input  wire logic                           aaMemSel,
    input  wire logic                           abMemSel,
    input  wire logic                           bbMemSel,
    input  wire logic                           cMemSel,
    output logic      [slicePkg::halfWidth-1:0] mulAOpA,
    output logic      [slicePkg::halfWidth-1:0] mulAOpB,
    output logic      [slicePkg::halfWidth-1:0] mulBOpA,
    output logic      [slicePkg::halfWidth-1:0] mulBOpB,
    output logic      [slicePkg::wordWidth-1:0] cWord
);

    logic [slicePkg::halfWidth-1:0] mem0Low;
    logic [slicePkg::halfWidth-1:0] mem0High;
    logic [slicePkg::halfWidth-1:0] mem1Low;
    logic [slicePkg::halfWidth-1:0] mem1High;

    logic [slicePkg::halfWidth-1:0] mem1LowPrev; // Low half of the previous enabled Mem1
    logic [slicePkg::wordWidth-1:0] cWordSelected;
    logic [slicePkg::wordWidth-1:0] cWordStage1;

    assign mem0Low  = mem0[slicePkg::halfWidth-1:0];
    assign mem0High = mem0[slicePkg::wordWidth-1:slicePkg::halfWidth];
    assign mem1Low  = mem1[slicePkg::halfWidth-1:0];
    assign mem1High = mem1[slicePkg::wordWidth-1:slicePkg::halfWidth];

    assign mulAOpA = aaMemSel ? mem0High : mem0Low;
    assign mulAOpB = abMemSel ? mem1High : mem1Low;

    // Multiplier B always takes the high half of Mem0
    assign mulBOpA = mem0High;

    // Select 0 reaches back one enabled cycle for the low half of Mem1
    assign mulBOpB = bbMemSel ? mem1High : mem1LowPrev;

    assign cWordSelected = cMemSel ? mem1 : mem0;

    always_ff @(posedge CLK0) begin
        if (rst) begin
            mem1LowPrev <= '0;
        end else if (ce0) begin
            mem1LowPrev <= mem1Low;
        end
    end

    // Two stages so the C word meets the registered products
    always_ff @(posedge CLK0) begin
        if (rst) begin
            cWordStage1 <= '0;
            cWord       <= '0;
        end else if (ce0) begin
            cWordStage1 <= cWordSelected;
            cWord       <= cWordStage1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/slicePkg.sv
`default_nettype none

package slicePkg;

    // Multiplier operands are half-words of a memory word
    localparam int halfWidth = 18;
    localparam int wordWidth = 36; // Memory word and raw product width
    localparam int accWidth  = 54; // Post-adder and result width

    // Guard bits above the aligned C word. They hold its sign extension
    localparam int qShift = 2;

    // Low bit of the C word inside the sum, also the low bit of result
    localparam int resultLsb = accWidth - wordWidth - qShift;

    // Bits above the raw product when it is widened for the adder
    localparam int productExtend = accWidth - wordWidth;

    // Third-term selection for the post-adder
    localparam int cSelWidth = 2;

    localparam logic [cSelWidth-1:0] cSelZero     = 2'b00;
    localparam logic [cSelWidth-1:0] cSelWord     = 2'b01; // Aligned C word
    localparam logic [cSelWidth-1:0] cSelFeedback = 2'b10; // Previous result54
    // Code 2'b11 is unused and selects zero like cSelZero

endpackage

`default_nettype wire
